// File: src/exec_pkg.sv
`default_nettype none

package exec_pkg;

	// default word and register address widths.
	localparam int DEF_DATA_W = 16;
	localparam int DEF_REG_AW = 3;

	// one command per operation, three bit code.
	typedef enum logic [2:0] {
		OP_ADD = 3'd0, // rd = rs1 + rs2.
		OP_SUB = 3'd1, // rd = rs1 - rs2.
		OP_AND = 3'd2, // rd = rs1 & rs2.
		OP_XOR = 3'd3, // rd = rs1 ^ rs2.
		OP_LDI = 3'd4, // rd = imm.
		OP_SLL = 3'd5, // rd = rs1 << imm[3:0].
		OP_SRL = 3'd6, // rd = rs1 >> imm[3:0].
		OP_NOP = 3'd7  // no write, result is zero.
	} op_t;

	// shifts walk through the SHIFT state one bit at a time.
	function automatic logic is_shift(input op_t op);
		logic shift_op;
		shift_op = (op == OP_SLL) || (op == OP_SRL);
		return shift_op;
	endfunction

	// only OP_NOP leaves the register file alone.
	function automatic logic writes_reg(input op_t op);
		logic wr;
		wr = (op != OP_NOP);
		return wr;
	endfunction

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
	parameter int DATA_W = 16,
	parameter int REG_AW = 3
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              wr_en,
	input  logic [REG_AW-1:0] wr_addr,
	input  logic [DATA_W-1:0] wr_data,
	input  logic [REG_AW-1:0] rd_addr_a,
	input  logic [REG_AW-1:0] rd_addr_b,
	output logic [DATA_W-1:0] rd_data_a,
	output logic [DATA_W-1:0] rd_data_b
);

	localparam int NUM_REGS = 2 ** REG_AW;

	logic [DATA_W-1:0]   regs [NUM_REGS];
	logic [NUM_REGS-1:0] wr_dec;

	// write decoder is gated by the enable.
	always_comb begin
		wr_dec = '0;
		if (wr_en) begin
			wr_dec[wr_addr] = 1'b1;
		end
	end

	// one enabled register per entry.
	for (genvar i = 0; i < NUM_REGS; i++) begin : g_entry
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				regs[i] <= '0;
			end else if (wr_dec[i]) begin
				regs[i] <= wr_data;
			end
		end
	end

	// read ports, full muxes over the entries.
	always_comb begin
		rd_data_a = '0;
		rd_data_b = '0;
		for (int j = 0; j < NUM_REGS; j++) begin
			if (rd_addr_a == REG_AW'(j)) begin
				rd_data_a = regs[j];
			end
			if (rd_addr_b == REG_AW'(j)) begin
				rd_data_b = regs[j];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/exec_alu.sv
`timescale 1ns/100ps
`default_nettype none

module exec_alu
	import exec_pkg::*;
#(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              arst_n,
	input  op_t               op_cur,
	input  logic [DATA_W-1:0] imm_cur,
	input  logic [DATA_W-1:0] opa,
	input  logic [DATA_W-1:0] opb,
	input  logic              load,
	input  logic              step,
	output logic [DATA_W-1:0] result
);

	logic [DATA_W-1:0] alu_val;
	logic [DATA_W-1:0] work_q;

	// single cycle operations, shifts pass source 1 through.
	always_comb begin
		unique case (op_cur)
			OP_ADD: begin
				alu_val = opa + opb; // wraps.
			end
			OP_SUB: begin
				alu_val = opa - opb;
			end
			OP_AND: begin
				alu_val = opa & opb;
			end
			OP_XOR: begin
				alu_val = opa ^ opb;
			end
			OP_LDI: begin
				alu_val = imm_cur;
			end
			OP_SLL, OP_SRL: begin
				alu_val = opa; // shifted later, one bit per step.
			end
			default: begin
				alu_val = '0; // OP_NOP.
			end
		endcase
	end

	// work register, load wins over step.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			work_q <= '0;
		end else if (load) begin
			work_q <= alu_val;
		end else if (step) begin
			if (op_cur == OP_SRL) begin
				work_q <= {1'b0, work_q[DATA_W-1:1]}; // zero fill from the top.
			end else begin
				work_q <= {work_q[DATA_W-2:0], 1'b0};
			end
		end
	end

	assign result = work_q;

endmodule

`default_nettype wire

// File: src/shift_counter.sv
`timescale 1ns/100ps
`default_nettype none

module shift_counter #(
	parameter int CNT_W = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cnt_load,
	input  logic [CNT_W-1:0] amount,
	input  logic             cnt_dec,
	output logic             cnt_zero
);

	logic [CNT_W-1:0] count;

	// count holds the steps left after the current one,
	// so zero marks the last shift cycle.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (cnt_load) begin
			count <= amount - 1'b1; // unused when amount is zero.
		end else if (cnt_dec && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	assign cnt_zero = (count == '0);

endmodule

`default_nettype wire

// File: src/exec_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module exec_ctrl
	import exec_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int REG_AW = 3
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  op_t               op,
	input  logic [REG_AW-1:0] rd_sel,
	input  logic [REG_AW-1:0] rs1_sel,
	input  logic [REG_AW-1:0] rs2_sel,
	input  logic [DATA_W-1:0] imm,
	input  logic              cnt_zero,
	output op_t               op_cur,
	output logic [DATA_W-1:0] imm_cur,
	output logic [REG_AW-1:0] rd_addr_a,
	output logic [REG_AW-1:0] rd_addr_b,
	output logic              wr_en,
	output logic [REG_AW-1:0] wr_addr,
	output logic              load,
	output logic              step,
	output logic              cnt_load,
	output logic              cnt_dec,
	output logic              busy,
	output logic              done
);

	localparam int SH_W = $clog2(DATA_W);

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		EXEC  = 2'd1,
		SHIFT = 2'd2,
		WB    = 2'd3
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   accept;
	logic   no_shift;

	assign accept = start && (state == IDLE); // starts while busy are dropped.

	// amount zero skips SHIFT, the counter is not loaded yet in EXEC.
	assign no_shift = !is_shift(op_cur) || (imm_cur[SH_W-1:0] == '0);

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (accept) begin
					state_nxt = EXEC;
				end
			end
			EXEC: begin
				state_nxt = no_shift ? WB : SHIFT;
			end
			SHIFT: begin
				if (cnt_zero) begin
					state_nxt = WB; // last step moves this cycle.
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= IDLE;
			op_cur <= OP_NOP;
		end else begin
			state <= state_nxt;
			if (accept) begin
				op_cur <= op;
			end
		end
	end

	// command payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			imm_cur   <= imm;
			wr_addr   <= rd_sel;
			rd_addr_a <= rs1_sel;
			rd_addr_b <= rs2_sel;
		end
	end

	assign load     = (state == EXEC);
	assign cnt_load = (state == EXEC) && is_shift(op_cur);
	assign step     = (state == SHIFT);
	assign cnt_dec  = step; // counter tracks the shifter.
	assign wr_en    = (state == WB) && writes_reg(op_cur);
	assign done     = (state == WB);
	assign busy     = (state != IDLE);

endmodule

`default_nettype wire

// File: src/exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module exec_top
	import exec_pkg::*;
#(
	parameter int DATA_W = DEF_DATA_W,
	parameter int REG_AW = DEF_REG_AW
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              start,
	input  op_t               op,
	input  logic [REG_AW-1:0] rd_sel,
	input  logic [REG_AW-1:0] rs1_sel,
	input  logic [REG_AW-1:0] rs2_sel,
	input  logic [DATA_W-1:0] imm,
	output logic              busy,
	output logic              done,
	output logic [DATA_W-1:0] result
);

	localparam int CNT_W = $clog2(DATA_W);

	op_t               op_cur;
	logic [DATA_W-1:0] imm_cur;
	logic [REG_AW-1:0] rd_addr_a;
	logic [REG_AW-1:0] rd_addr_b;
	logic [REG_AW-1:0] wr_addr;
	logic              wr_en;
	logic [DATA_W-1:0] rd_data_a;
	logic [DATA_W-1:0] rd_data_b;
	logic              load;
	logic              step;
	logic              cnt_load;
	logic              cnt_dec;
	logic              cnt_zero;

	exec_ctrl #(.DATA_W(DATA_W), .REG_AW(REG_AW)) u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.op        (op),
		.rd_sel    (rd_sel),
		.rs1_sel   (rs1_sel),
		.rs2_sel   (rs2_sel),
		.imm       (imm),
		.cnt_zero  (cnt_zero),
		.op_cur    (op_cur),
		.imm_cur   (imm_cur),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.load      (load),
		.step      (step),
		.cnt_load  (cnt_load),
		.cnt_dec   (cnt_dec),
		.busy      (busy),
		.done      (done)
	);

	// write data is the ALU work register.
	reg_file #(.DATA_W(DATA_W), .REG_AW(REG_AW)) u_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (result),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	exec_alu #(.DATA_W(DATA_W)) u_alu (
		.clk     (clk),
		.arst_n  (arst_n),
		.op_cur  (op_cur),
		.imm_cur (imm_cur),
		.opa     (rd_data_a),
		.opb     (rd_data_b),
		.load    (load),
		.step    (step),
		.result  (result)
	);

	shift_counter #(.CNT_W(CNT_W)) u_cnt (
		.clk      (clk),
		.arst_n   (arst_n),
		.cnt_load (cnt_load),
		.amount   (imm_cur[CNT_W-1:0]), // low immediate bits.
		.cnt_dec  (cnt_dec),
		.cnt_zero (cnt_zero)
	);

endmodule

`default_nettype wire

// File: verification/exec_props.sv
`timescale 1ns/100ps
`default_nettype none

module exec_props (
	input logic clk,
	input logic arst_n,
	input logic busy,
	input logic done
);

	// done is a one cycle pulse.
	a_done_pulse: assert property (
		@(posedge clk) disable iff (!arst_n) done |=> !done
	) else $error("done stayed high for two cycles");

	// the write-back cycle still counts as busy.
	a_done_busy: assert property (
		@(posedge clk) disable iff (!arst_n) done |-> busy
	) else $error("done high while busy is low");

	// slot frees right after write-back.
	a_busy_drop: assert property (
		@(posedge clk) disable iff (!arst_n) done |=> !busy
	) else $error("busy still high in the cycle after done");

endmodule

bind exec_top exec_props u_props (
	.clk    (clk),
	.arst_n (arst_n),
	.busy   (busy),
	.done   (done)
);

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 8
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release away from the rising edge.
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verification/exec_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_tb
	import exec_pkg::*;
();

	localparam int DW       = DEF_DATA_W;
	localparam int AW       = DEF_REG_AW;
	localparam int NREG     = 2 ** AW;
	localparam int LOW_W    = DW - AW;
	localparam int WAIT_MAX = 40;

	logic          clk;
	logic          arst_n;
	logic          start;
	op_t           op;
	logic [AW-1:0] rd_sel;
	logic [AW-1:0] rs1_sel;
	logic [AW-1:0] rs2_sel;
	logic [DW-1:0] imm;
	logic          busy;
	logic          done;
	logic [DW-1:0] result;

	logic [DW-1:0] model [NREG];
	logic [15:0]   lfsr_state;
	int            errors;
	int            test_errors;
	int            tests_pass;
	int            tests_fail;

	tb_clock #(.PERIOD(40), .RST_CYCLES(8)) u_clock (.clk(clk), .arst_n(arst_n));

	exec_top #(.DATA_W(DW), .REG_AW(AW)) dut0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.op      (op),
		.rd_sel  (rd_sel),
		.rs1_sel (rs1_sel),
		.rs2_sel (rs2_sel),
		.imm     (imm),
		.busy    (busy),
		.done    (done),
		.result  (result)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken.
	function automatic logic [DW-1:0] take_bits(input int n);
		logic [DW-1:0] val;
		logic          fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			val = {val[DW-2:0], fb};
		end
		return val;
	endfunction

	// expected write value per opcode.
	function automatic logic [DW-1:0] model_result(input op_t f_op, input logic [DW-1:0] a,
			input logic [DW-1:0] b, input logic [DW-1:0] k);
		logic [DW-1:0] r;
		case (f_op)
			OP_ADD: r = a + b;
			OP_SUB: r = a - b;
			OP_AND: r = a & b;
			OP_XOR: r = a ^ b;
			OP_LDI: r = k;
			OP_SLL: r = a << k[3:0];
			OP_SRL: r = a >> k[3:0];
			default: r = '0;
		endcase
		return r;
	endfunction

	function automatic op_t pick_arith(input logic [1:0] sel);
		op_t o;
		case (sel)
			2'd0: o = OP_ADD;
			2'd1: o = OP_SUB;
			2'd2: o = OP_AND;
			default: o = OP_XOR;
		endcase
		return o;
	endfunction

	task automatic open_test();
		test_errors = errors;
	endtask

	task automatic close_test(input string name);
		if (errors == test_errors) begin
			tests_pass++;
			$display("test %s: ok", name);
		end else begin
			tests_fail++;
			$display("test %s: %0d errors", name, errors - test_errors);
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (busy && n < WAIT_MAX) begin
			@(negedge clk);
			n++;
		end
		assert (!busy) else begin
			$display("slice stayed busy for %0d cycles", WAIT_MAX);
			errors++;
		end
	endtask

	// poke pulses a second start mid command.
	task automatic issue_cmd(input op_t c_op, input logic [AW-1:0] c_rd,
			input logic [AW-1:0] c_rs1, input logic [AW-1:0] c_rs2,
			input logic [DW-1:0] c_imm, input int exp_lat, input bit poke);
		logic [DW-1:0] exp_val;
		int            n;
		bit            got;
		exp_val = model_result(c_op, model[c_rs1], model[c_rs2], c_imm);
		wait_idle();
		@(posedge clk);
		start   <= 1'b1;
		op      <= c_op;
		rd_sel  <= c_rd;
		rs1_sel <= c_rs1;
		rs2_sel <= c_rs2;
		imm     <= c_imm;
		n = 0;
		got = 1'b0;
		while (!got && n < WAIT_MAX) begin
			@(posedge clk);
			n++;
			if (poke && n == 3) begin
				start  <= 1'b1; // should be dropped.
				op     <= OP_LDI;
				rd_sel <= AW'(5);
				imm    <= ~model[5];
			end else begin
				start <= 1'b0;
			end
			@(negedge clk);
			got = done;
			assert (busy) else begin
				$display("ERROR: busy expected 0x1 got 0x%0h (%s cycle %0d)",
					busy, c_op.name(), n);
				errors++;
			end
		end
		assert (got) else begin
			$display("no done within %0d cycles of start for %s", WAIT_MAX, c_op.name());
			errors++;
		end
		if (got) begin
			assert (result == exp_val) else begin
				$display("ERROR: result expected 0x%04h got 0x%04h (%s rd %0d)",
					exp_val, result, c_op.name(), c_rd);
				errors++;
			end
			assert (n == exp_lat) else begin
				$display("done came %0d cycles after start, expected %0d", n, exp_lat);
				errors++;
			end
			if (c_op != OP_NOP) begin
				model[c_rd] = exp_val;
			end
		end
	endtask

	// and with itself rewrites the same value.
	task automatic read_back_all();
		for (int r = 0; r < NREG; r++) begin
			issue_cmd(OP_AND, AW'(r), AW'(r), AW'(r), '0, 2, 1'b0);
		end
	endtask

	task automatic reset_and_load();
		open_test();
		assert (result == '0) else begin
			$display("ERROR: result after reset expected 0x0000 got 0x%04h", result);
			errors++;
		end
		read_back_all();
		for (int r = 0; r < NREG; r++) begin
			issue_cmd(OP_LDI, AW'(r), AW'(0), AW'(0), take_bits(DW), 2, 1'b0);
		end
		close_test("reset_load");
	endtask

	task automatic arith_ops();
		logic [AW-1:0] rd;
		logic [AW-1:0] rs1;
		logic [AW-1:0] rs2;
		open_test();
		for (int i = 0; i < 12; i++) begin
			rd  = AW'(take_bits(AW));
			rs1 = AW'(take_bits(AW));
			rs2 = AW'(take_bits(AW));
			if (i == 0) begin
				rs2 = rs1;
			end else if (i == 1) begin
				rd = rs1;
			end else if (i == 2) begin
				rd = rs2;
			end
			issue_cmd(pick_arith(2'(i)), rd, rs1, rs2, take_bits(DW), 2, 1'b0);
		end
		close_test("arith");
	endtask

	task automatic shift_ops();
		int            fixed_amt [4] = '{0, 1, 7, 15};
		op_t           sop;
		logic [3:0]    amt;
		logic [AW-1:0] src;
		logic [AW-1:0] dst;
		logic [DW-1:0] upper;
		open_test();
		for (int d = 0; d < 2; d++) begin
			sop = (d == 0) ? OP_SLL : OP_SRL;
			for (int i = 0; i < 5; i++) begin
				amt = (i < 4) ? 4'(fixed_amt[i]) : 4'(take_bits(4));
				src = AW'(take_bits(AW));
				dst = AW'(take_bits(AW));
				upper = take_bits(DW - 4); // must not reach the shift amount.
				issue_cmd(OP_LDI, src, src, src, take_bits(DW), 2, 1'b0);
				issue_cmd(sop, dst, src, src, {upper[DW-5:0], amt}, 2 + int'(amt), 1'b0);
			end
		end
		close_test("shifts");
	endtask

	task automatic ignored_start_nop();
		open_test();
		issue_cmd(OP_LDI, AW'(2), AW'(0), AW'(0), take_bits(DW), 2, 1'b0);
		issue_cmd(OP_SLL, AW'(3), AW'(2), AW'(2), DW'(15), 17, 1'b1);
		read_back_all();
		issue_cmd(OP_NOP, AW'(1), AW'(1), AW'(1), take_bits(DW), 2, 1'b0);
		read_back_all();
		close_test("busy_nop");
	endtask

	task automatic reg_independence();
		logic [AW-1:0] k;
		open_test();
		issue_cmd(OP_LDI, AW'(0), AW'(0), AW'(0), '0, 2, 1'b0); // r0 is the zero source.
		for (int r = 1; r < NREG; r++) begin
			issue_cmd(OP_LDI, AW'(r), AW'(0), AW'(0), {AW'(r), LOW_W'(take_bits(LOW_W))},
				2, 1'b0);
		end
		k = AW'(1 + (take_bits(AW) % (NREG - 1)));
		issue_cmd(OP_LDI, k, k, k, ~model[k], 2, 1'b0);
		for (int r = 0; r < NREG; r++) begin
			issue_cmd(OP_ADD, AW'(r), AW'(r), AW'(0), '0, 2, 1'b0);
		end
		close_test("reg_indep");
	endtask

	initial begin
		int n;
		start      = 1'b0;
		op         = OP_NOP;
		rd_sel     = '0;
		rs1_sel    = '0;
		rs2_sel    = '0;
		imm        = '0;
		lfsr_state = 16'd45;
		errors     = 0;
		tests_pass = 0;
		tests_fail = 0;
		for (int r = 0; r < NREG; r++) begin
			model[r] = '0;
		end
		n = 0;
		while (arst_n !== 1'b1 && n < 20) begin
			@(negedge clk);
			n++;
		end
		assert (arst_n === 1'b1) else begin
			$display("reset was never released");
			errors++;
		end
		reset_and_load();
		arith_ops();
		shift_ops();
		ignored_start_nop();
		reg_independence();
		$display("tests passed %0d, failed %0d", tests_pass, tests_fail);
		if (tests_fail == 0 && errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
src/exec_pkg.sv
src/reg_file.sv
src/exec_alu.sv
src/shift_counter.sv
src/exec_ctrl.sv
src/exec_top.sv
verification/exec_props.sv
verification/tb_clock.sv
verification/exec_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status follows the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module exec_tb -o exec_sim

out=$(./obj_dir/exec_sim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "RESULT: PASS"
